/* exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Data path and address width
`define EXEC_XLEN 32

// Register file address width
`define EXEC_REG_AW 5

// Cache port encodings
`define EXEC_CMD_W 2
`define EXEC_RSP_W 3

// Load/store sequencer issued flag after reset
`define EXEC_SEQ_RST_VAL 1'b0

`endif

/* rv_isa_pkg.sv */
`include "exec_settings.svh"

package rv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct7 for base and alternate (SUB, SRA) forms
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    // mcause exception codes
    localparam logic [`EXEC_XLEN-1:0] EXC_ILLEGAL_INSTR      = 2;
    localparam logic [`EXEC_XLEN-1:0] EXC_LOAD_MISALIGNED    = 4;
    localparam logic [`EXEC_XLEN-1:0] EXC_LOAD_ACCESS_FAULT  = 5;
    localparam logic [`EXEC_XLEN-1:0] EXC_STORE_MISALIGNED   = 6;
    localparam logic [`EXEC_XLEN-1:0] EXC_STORE_ACCESS_FAULT = 7;
    localparam logic [`EXEC_XLEN-1:0] EXC_LOAD_PAGE_FAULT    = 13;
    localparam logic [`EXEC_XLEN-1:0] EXC_STORE_PAGE_FAULT   = 15;

    typedef enum logic [3:0] {
        CLS_ALU,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LUI,
        CLS_AUIPC,
        CLS_LOAD,
        CLS_STORE,
        CLS_ILLEGAL
    } instr_class_e;

    // alu_imm selects the I-type immediate as second ALU operand
    typedef struct packed {
        instr_class_e             cls;
        logic                     alu_imm;
        logic [`EXEC_REG_AW-1:0]  rd;
        logic [`EXEC_REG_AW-1:0]  rs1;
        logic [`EXEC_REG_AW-1:0]  rs2;
        logic [2:0]               funct3;
        logic [6:0]               funct7;
        logic [`EXEC_XLEN-1:0]    imm_i;
        logic [`EXEC_XLEN-1:0]    imm_s;
        logic [`EXEC_XLEN-1:0]    imm_b;
        logic [`EXEC_XLEN-1:0]    imm_u;
        logic [`EXEC_XLEN-1:0]    imm_j;
    } decoded_t;

endpackage

/* exec_bus_pkg.sv */
`include "exec_settings.svh"

package exec_bus_pkg;

    typedef enum logic [`EXEC_CMD_W-1:0] {
        CACHE_CMD_NONE,
        CACHE_CMD_LOAD,
        CACHE_CMD_STORE
    } cache_cmd_e;

    typedef enum logic [`EXEC_RSP_W-1:0] {
        CACHE_RSP_NONE,
        CACHE_RSP_DONE,
        CACHE_RSP_MISALIGNED,
        CACHE_RSP_ACCESS_FAULT,
        CACHE_RSP_PAGE_FAULT
    } cache_rsp_e;

    // Instruction presented by fetch, held until ready
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] instr;
        logic [`EXEC_XLEN-1:0] pc;
    } fetch_to_exec_t;

    // Redirect and exception info, valid in the ready cycle only
    typedef struct packed {
        logic                  ready;
        logic                  branch_taken;
        logic [`EXEC_XLEN-1:0] branch_target;
        logic                  exc_start;
        logic [`EXEC_XLEN-1:0] exc_epc;
    } exec_to_fetch_t;

    typedef struct packed {
        cache_cmd_e            cmd;
        logic [`EXEC_XLEN-1:0] address;
        logic [2:0]            load_type;
        logic [1:0]            store_type;
        logic [`EXEC_XLEN-1:0] store_data;
    } cache_req_t;

    typedef struct packed {
        cache_rsp_e            response;
        logic [`EXEC_XLEN-1:0] load_data;
    } cache_rsp_t;

    typedef struct packed {
        logic                    write;
        logic [`EXEC_REG_AW-1:0] addr;
        logic [`EXEC_XLEN-1:0]   wdata;
    } rd_write_t;

endpackage

/* rv_decode.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module rv_decode (
    input  logic [`EXEC_XLEN-1:0] instr,
    output rv_isa_pkg::decoded_t  dec
);
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       sign;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign sign   = instr[31];

    // Raw fields and immediates
    always_comb begin
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.funct3  = funct3;
        dec.funct7  = instr[31:25];
        dec.alu_imm = (opcode == OPC_OP_IMM);

        dec.imm_i = {{(`EXEC_XLEN-12){sign}}, instr[31:20]};
        dec.imm_s = {{(`EXEC_XLEN-12){sign}}, instr[31:25], instr[11:7]};
        dec.imm_b = {{(`EXEC_XLEN-13){sign}}, instr[31], instr[7],
                     instr[30:25], instr[11:8], 1'b0};
        dec.imm_u = {instr[31:12], 12'h000};
        dec.imm_j = {{(`EXEC_XLEN-21){sign}}, instr[31], instr[19:12],
                     instr[20], instr[30:21], 1'b0};
    end

    // Class from opcode, malformed encodings go to ILLEGAL
    always_comb begin
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                dec.cls = CLS_ALU;
            end
            OPC_JAL: begin
                dec.cls = CLS_JAL;
            end
            OPC_JALR: begin
                dec.cls = (funct3 != 3'b000) ? CLS_ILLEGAL : CLS_JALR;
            end
            OPC_BRANCH: begin
                // Unused branch funct3 is caught by the comparator
                dec.cls = CLS_BRANCH;
            end
            OPC_LUI: begin
                dec.cls = CLS_LUI;
            end
            OPC_AUIPC: begin
                dec.cls = CLS_AUIPC;
            end
            OPC_LOAD: begin
                // LD, LWU and funct3 7 do not exist on RV32
                if (funct3 == 3'd3 || funct3 == 3'd6 || funct3 == 3'd7) begin
                    dec.cls = CLS_ILLEGAL;
                end else begin
                    dec.cls = CLS_LOAD;
                end
            end
            OPC_STORE: begin
                dec.cls = funct3[2] ? CLS_ILLEGAL : CLS_STORE;
            end
            default: begin
                // Includes SYSTEM and FENCE
                dec.cls = CLS_ILLEGAL;
            end
        endcase
    end

endmodule

/* rv_alu.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module rv_alu (
    input  rv_isa_pkg::decoded_t  dec,
    input  logic [`EXEC_XLEN-1:0] rs1_data,
    input  logic [`EXEC_XLEN-1:0] rs2_data,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  illegal
);
    import rv_isa_pkg::*;

    logic [`EXEC_XLEN-1:0]        op_b;
    logic [4:0]                   shamt;
    logic                         alt;
    logic signed [`EXEC_XLEN-1:0] sra_res;

    assign op_b    = dec.alu_imm ? dec.imm_i : rs2_data;
    assign shamt   = op_b[4:0];
    assign alt     = (dec.funct7 == F7_ALT);
    assign sra_res = $signed(rs1_data) >>> shamt;

    always_comb begin
        case (dec.funct3)
            F3_ADD_SUB: begin
                // ADDI has no subtract form
                if (alt && !dec.alu_imm) begin
                    result = rs1_data - op_b;
                end else begin
                    result = rs1_data + op_b;
                end
            end
            F3_SLL:     result = rs1_data << shamt;
            F3_SLT:     result = {{(`EXEC_XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            F3_SLTU:    result = {{(`EXEC_XLEN-1){1'b0}}, rs1_data < op_b};
            F3_XOR:     result = rs1_data ^ op_b;
            F3_SRL_SRA: result = alt ? sra_res : rs1_data >> shamt;
            F3_OR:      result = rs1_data | op_b;
            default:    result = rs1_data & op_b;
        endcase
    end

    // funct7 checks, immediate forms only constrain the shifts
    always_comb begin
        illegal = 1'b0;
        if (!dec.alu_imm) begin
            if (dec.funct7 != F7_BASE) begin
                illegal = !(alt && (dec.funct3 == F3_ADD_SUB || dec.funct3 == F3_SRL_SRA));
            end
        end else if (dec.funct3 == F3_SLL) begin
            illegal = (dec.funct7 != F7_BASE);
        end else if (dec.funct3 == F3_SRL_SRA) begin
            illegal = !(dec.funct7 == F7_BASE || alt);
        end
    end

endmodule

/* rv_branch_cond.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module rv_branch_cond (
    input  logic [2:0]            funct3,
    input  logic [`EXEC_XLEN-1:0] rs1_data,
    input  logic [`EXEC_XLEN-1:0] rs2_data,
    output logic                  taken,
    output logic                  illegal
);
    import rv_isa_pkg::*;

    always_comb begin
        taken   = 1'b0;
        illegal = 1'b0;
        case (funct3)
            F3_BEQ:  taken = (rs1_data == rs2_data);
            F3_BNE:  taken = (rs1_data != rs2_data);
            F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            F3_BLTU: taken = (rs1_data < rs2_data);
            F3_BGEU: taken = (rs1_data >= rs2_data);
            default: begin
                // funct3 2 and 3 are unassigned
                illegal = 1'b1;
            end
        endcase
    end

endmodule

/* lsu_sequencer.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module lsu_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv_isa_pkg::decoded_t     dec,
    input  logic [`EXEC_XLEN-1:0]    rs1_data,
    input  logic [`EXEC_XLEN-1:0]    rs2_data,
    output exec_bus_pkg::cache_req_t cache_req,
    input  exec_bus_pkg::cache_rsp_t cache_rsp,
    output logic                     done,
    output logic                     exc,
    output logic [`EXEC_XLEN-1:0]    exc_cause
);
    import rv_isa_pkg::*;
    import exec_bus_pkg::*;

    logic issued;
    logic is_load;
    logic is_store;
    logic rsp_done;
    logic rsp_err;

    assign is_load  = (dec.cls == CLS_LOAD);
    assign is_store = (dec.cls == CLS_STORE);

    // A response only counts once the command has been seen for a cycle
    assign rsp_done = issued && (cache_rsp.response == CACHE_RSP_DONE);
    assign rsp_err  = issued && (cache_rsp.response == CACHE_RSP_MISALIGNED ||
                                 cache_rsp.response == CACHE_RSP_ACCESS_FAULT ||
                                 cache_rsp.response == CACHE_RSP_PAGE_FAULT);

    assign done = (is_load || is_store) && (rsp_done || rsp_err);
    assign exc  = (is_load || is_store) && rsp_err;

    always_comb begin
        cache_req.address    = rs1_data + (is_store ? dec.imm_s : dec.imm_i);
        cache_req.load_type  = dec.funct3;
        cache_req.store_type = dec.funct3[1:0];
        cache_req.store_data = rs2_data;

        // Command held until the response cycle
        if (is_load && !done) begin
            cache_req.cmd = CACHE_CMD_LOAD;
        end else if (is_store && !done) begin
            cache_req.cmd = CACHE_CMD_STORE;
        end else begin
            cache_req.cmd = CACHE_CMD_NONE;
        end
    end

    // Cause from response kind and direction
    always_comb begin
        case (cache_rsp.response)
            CACHE_RSP_MISALIGNED:
                exc_cause = is_store ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
            CACHE_RSP_ACCESS_FAULT:
                exc_cause = is_store ? EXC_STORE_ACCESS_FAULT : EXC_LOAD_ACCESS_FAULT;
            CACHE_RSP_PAGE_FAULT:
                exc_cause = is_store ? EXC_STORE_PAGE_FAULT : EXC_LOAD_PAGE_FAULT;
            default:
                exc_cause = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issued <= `EXEC_SEQ_RST_VAL;
        end else if (is_load || is_store) begin
            if (!issued) begin
                issued <= 1'b1;
            end else if (rsp_done || rsp_err) begin
                issued <= 1'b0;
            end
        end
    end

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module rv_execute (
    input  logic                         clk,
    input  logic                         rst_n,
    input  exec_bus_pkg::fetch_to_exec_t f2e,
    output exec_bus_pkg::exec_to_fetch_t e2f,
    output logic [`EXEC_XLEN-1:0]        exc_cause,
    output logic [`EXEC_REG_AW-1:0]      rs1_addr,
    output logic [`EXEC_REG_AW-1:0]      rs2_addr,
    input  logic [`EXEC_XLEN-1:0]        rs1_data,
    input  logic [`EXEC_XLEN-1:0]        rs2_data,
    output exec_bus_pkg::rd_write_t      rd,
    output exec_bus_pkg::cache_req_t     cache_req,
    input  exec_bus_pkg::cache_rsp_t     cache_rsp
);
    import rv_isa_pkg::*;

    decoded_t              dec;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic                  alu_illegal;
    logic                  br_taken;
    logic                  br_illegal;
    logic                  lsu_done;
    logic                  lsu_exc;
    logic [`EXEC_XLEN-1:0] lsu_exc_cause;
    logic                  illegal;
    logic                  wr_en;

    rv_decode i_rv_decode (
        .instr (f2e.instr),
        .dec   (dec)
    );

    rv_alu i_rv_alu (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result),
        .illegal  (alu_illegal)
    );

    rv_branch_cond i_rv_branch_cond (
        .funct3   (dec.funct3),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .taken    (br_taken),
        .illegal  (br_illegal)
    );

    lsu_sequencer i_lsu_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .cache_req (cache_req),
        .cache_rsp (cache_rsp),
        .done      (lsu_done),
        .exc       (lsu_exc),
        .exc_cause (lsu_exc_cause)
    );

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    // Write-back value
    always_comb begin
        case (dec.cls)
            CLS_LOAD:           rd.wdata = cache_rsp.load_data;
            CLS_LUI:            rd.wdata = dec.imm_u;
            CLS_AUIPC:          rd.wdata = f2e.pc + dec.imm_u;
            CLS_JAL, CLS_JALR:  rd.wdata = f2e.pc + 4;
            default:            rd.wdata = alu_result;
        endcase
    end

    // Ready, redirect and exception per class
    always_comb begin
        e2f.ready         = 1'b1;
        e2f.branch_taken  = 1'b0;
        e2f.branch_target = f2e.pc + dec.imm_b;
        illegal           = 1'b0;
        wr_en             = 1'b0;
        case (dec.cls)
            CLS_ALU: begin
                illegal = alu_illegal;
                wr_en   = 1'b1;
            end
            CLS_JAL: begin
                e2f.branch_taken  = 1'b1;
                e2f.branch_target = f2e.pc + dec.imm_j;
                wr_en             = 1'b1;
            end
            CLS_JALR: begin
                e2f.branch_taken  = 1'b1;
                e2f.branch_target = (rs1_data + dec.imm_i) & ~`EXEC_XLEN'd1;
                wr_en             = 1'b1;
            end
            CLS_BRANCH: begin
                illegal          = br_illegal;
                e2f.branch_taken = br_taken && !br_illegal;
            end
            CLS_LUI, CLS_AUIPC: begin
                wr_en = 1'b1;
            end
            CLS_LOAD: begin
                e2f.ready = lsu_done;
                wr_en     = 1'b1;
            end
            CLS_STORE: begin
                e2f.ready = lsu_done;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        e2f.exc_start = illegal || lsu_exc;
        e2f.exc_epc   = f2e.pc;
        exc_cause     = illegal ? EXC_ILLEGAL_INSTR : lsu_exc_cause;
    end

    // x0 is never written, nor is rd on a trap
    assign rd.addr  = dec.rd;
    assign rd.write = wr_en && e2f.ready && !e2f.exc_start && (dec.rd != '0);

endmodule

/* tb_rv_execute.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module tb_rv_execute;
    import exec_bus_pkg::*;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // Word access width code for LW and SW
    localparam logic [2:0]  F3_WORD    = 3'd2;
    localparam logic [4:0]  DEST_REG   = 5'd3;
    localparam logic [31:0] PC0        = 32'h0000_1000;
    localparam logic [31:0] STORE_DATA = 32'hdead_beef;
    localparam logic [31:0] JUNK       = 32'hbad0_bad0;
    localparam int          RST_CYCLES = 10;
    localparam int          MAX_DELAY  = 4;

    // One table row with operands always in x1 and x2
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic        mem;
        cache_cmd_e  exp_cmd;
        logic [2:0]  exp_size;
        cache_rsp_e  rsp;
        logic [31:0] load_data;
        logic        exp_wr;
        logic [31:0] exp_wdata;
        logic        exp_taken;
        logic [31:0] exp_target;
        logic        exp_exc;
        logic [31:0] exp_cause;
        logic [31:0] exp_addr;
    } test_row_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    fetch_to_exec_t          f2e;
    exec_to_fetch_t          e2f;
    logic [`EXEC_XLEN-1:0]   exc_cause;
    logic [`EXEC_REG_AW-1:0] rs1_addr;
    logic [`EXEC_REG_AW-1:0] rs2_addr;
    logic [`EXEC_XLEN-1:0]   rs1_data;
    logic [`EXEC_XLEN-1:0]   rs2_data;
    rd_write_t               rd;
    cache_req_t              cache_req;
    cache_rsp_t              cache_rsp;

    logic [`EXEC_XLEN-1:0]   regs [32];
    test_row_t               rows [$];
    string                   names [$];
    int                      delays [$];
    integer                  seed;
    int                      errors = 0;
    int                      pass_cnt = 0;
    int                      fail_cnt = 0;
    int                      cycles = 0;
    int                      limit = 0;

    rv_execute i_rv_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .f2e       (f2e),
        .e2f       (e2f),
        .exc_cause (exc_cause),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rd        (rd),
        .cache_req (cache_req),
        .cache_rsp (cache_rsp)
    );

    always #10 clk = ~clk;

    // Register file read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: instruction did not retire within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Instruction encoders with rd in x3 unless given
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd_a);
        return {f7, 5'd2, 5'd1, f3, rd_a, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm, 5'd1, f3, DEST_REG, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [6:0] opc);
        return {imm, DEST_REG, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], DEST_REG, OPC_JAL};
    endfunction

    function automatic test_row_t base_row(input logic [31:0] instr, input logic [31:0] a,
                                           input logic [31:0] b);
        test_row_t r;
        r         = '0;
        r.instr   = instr;
        r.pc      = PC0;
        r.rs1_val = a;
        r.rs2_val = b;
        return r;
    endfunction

    task automatic push_row(input string name, input test_row_t r);
        int delay;
        delay = 0;
        if (r.mem) begin
            delay = 1 + int'($unsigned($random(seed)) % MAX_DELAY);
        end
        names.push_back(name);
        rows.push_back(r);
        delays.push_back(delay);
    endtask

    task automatic wb_row(input string name, input logic [31:0] instr, input logic [31:0] a,
                          input logic [31:0] b, input logic wr, input logic [31:0] wdata);
        test_row_t r;
        r           = base_row(instr, a, b);
        r.exp_wr    = wr;
        r.exp_wdata = wdata;
        push_row(name, r);
    endtask

    task automatic jump_row(input string name, input logic [31:0] instr, input logic [31:0] a,
                            input logic [31:0] target);
        test_row_t r;
        r            = base_row(instr, a, 32'd0);
        r.exp_wr     = 1'b1;
        r.exp_wdata  = PC0 + 32'd4;
        r.exp_taken  = 1'b1;
        r.exp_target = target;
        push_row(name, r);
    endtask

    task automatic branch_row(input string name, input logic [2:0] f3, input logic [12:0] imm,
                              input logic [31:0] a, input logic [31:0] b, input logic taken);
        test_row_t r;
        r            = base_row(b_type(imm, f3), a, b);
        r.exp_taken  = taken;
        r.exp_target = PC0 + {{19{imm[12]}}, imm};
        push_row(name, r);
    endtask

    // Errors trap with the given cause and a good load writes the cache data
    task automatic mem_row(input string name, input logic [31:0] instr, input logic [31:0] a,
                           input cache_rsp_e rsp, input logic [31:0] ldata,
                           input logic [31:0] cause, input logic [31:0] addr);
        test_row_t r;
        logic      store;
        store       = (instr[6:0] == OPC_STORE);
        r           = base_row(instr, a, STORE_DATA);
        r.mem       = 1'b1;
        r.exp_cmd   = store ? CACHE_CMD_STORE : CACHE_CMD_LOAD;
        // All table accesses are word sized
        r.exp_size  = F3_WORD;
        r.rsp       = rsp;
        r.load_data = ldata;
        r.exp_addr  = addr;
        r.exp_exc   = (rsp != CACHE_RSP_DONE);
        r.exp_cause = cause;
        r.exp_wr    = !store && (rsp == CACHE_RSP_DONE);
        r.exp_wdata = ldata;
        push_row(name, r);
    endtask

    task automatic illegal_row(input string name, input logic [31:0] instr);
        test_row_t r;
        r           = base_row(instr, 32'd0, 32'd0);
        r.exp_exc   = 1'b1;
        r.exp_cause = 32'd2;
        push_row(name, r);
    endtask

    task automatic fill_table();
        logic [31:0] lw_i;
        logic [31:0] lw_neg_i;
        logic [31:0] sw_i;
        lw_i     = i_type(12'h010, F3_WORD, OPC_LOAD);
        lw_neg_i = i_type(12'hffc, F3_WORD, OPC_LOAD);
        sw_i     = s_type(12'h008, F3_WORD);

        wb_row("add", r_type(7'h00, 3'd0, 5'd3), 32'd5, 32'd7, 1'b1, 32'd12);
        wb_row("sub", r_type(7'h20, 3'd0, 5'd3), 32'd5, 32'd7, 1'b1, 32'hffff_fffe);
        wb_row("slt", r_type(7'h00, 3'd2, 5'd3), 32'hffff_fffd, 32'd2, 1'b1, 32'd1);
        wb_row("sltu", r_type(7'h00, 3'd3, 5'd3), 32'hffff_fffd, 32'd2, 1'b1, 32'd0);
        wb_row("sra", r_type(7'h20, 3'd5, 5'd3), 32'h8000_0010, 32'd4, 1'b1, 32'hf800_0001);
        wb_row("srl", r_type(7'h00, 3'd5, 5'd3), 32'h8000_0010, 32'd4, 1'b1, 32'h0800_0001);
        wb_row("xor", r_type(7'h00, 3'd4, 5'd3), 32'hf0f0_f0f0, 32'h0ff0_0ff0, 1'b1,
               32'hff00_ff00);
        wb_row("addi_neg", i_type(12'hffb, 3'd0, OPC_OP_IMM), 32'd10, 32'd0, 1'b1, 32'd5);
        wb_row("slti_neg", i_type(12'hfff, 3'd2, OPC_OP_IMM), 32'hffff_fffe, 32'd0, 1'b1, 32'd1);
        wb_row("xori_neg", i_type(12'hfff, 3'd4, OPC_OP_IMM), 32'h1234_5678, 32'd0, 1'b1,
               32'hedcb_a987);
        wb_row("srai", i_type(12'h408, 3'd5, OPC_OP_IMM), 32'h8000_0000, 32'd0, 1'b1,
               32'hff80_0000);
        wb_row("add_x0", r_type(7'h00, 3'd0, 5'd0), 32'd5, 32'd7, 1'b0, 32'd0);
        wb_row("lui", u_type(20'habcde, OPC_LUI), 32'd0, 32'd0, 1'b1, 32'habcd_e000);
        wb_row("auipc", u_type(20'h00012, OPC_AUIPC), 32'd0, 32'd0, 1'b1, 32'h0001_3000);

        // Forward and backward offsets
        branch_row("beq_t", 3'd0, 13'h0010, 32'd5, 32'd5, 1'b1);
        branch_row("beq_nt", 3'd0, 13'h0010, 32'd5, 32'd6, 1'b0);
        branch_row("bne_t", 3'd1, 13'h1ff8, 32'd5, 32'd6, 1'b1);
        branch_row("bne_nt", 3'd1, 13'h1ff8, 32'd5, 32'd5, 1'b0);
        branch_row("blt_t", 3'd4, 13'h0010, 32'hffff_ffff, 32'd1, 1'b1);
        branch_row("blt_nt", 3'd4, 13'h0010, 32'd1, 32'hffff_ffff, 1'b0);
        branch_row("bge_t", 3'd5, 13'h1ff8, 32'd1, 32'hffff_ffff, 1'b1);
        branch_row("bge_nt", 3'd5, 13'h1ff8, 32'hffff_ffff, 32'd1, 1'b0);
        branch_row("bltu_t", 3'd6, 13'h0010, 32'd1, 32'hffff_ffff, 1'b1);
        branch_row("bltu_nt", 3'd6, 13'h0010, 32'hffff_ffff, 32'd1, 1'b0);
        branch_row("bgeu_t", 3'd7, 13'h0020, 32'hffff_ffff, 32'd1, 1'b1);
        branch_row("bgeu_nt", 3'd7, 13'h0020, 32'd1, 32'hffff_ffff, 1'b0);
        jump_row("jal", j_type(21'h000100), 32'd0, 32'h0000_1100);
        jump_row("jalr", i_type(12'h007, 3'd0, OPC_JALR), 32'h0000_2000, 32'h0000_2006);

        mem_row("lw", lw_i, 32'h2000, CACHE_RSP_DONE, 32'hcafe_f00d, 32'd0, 32'h2010);
        mem_row("lw_neg", lw_neg_i, 32'h2000, CACHE_RSP_DONE, 32'h1234_5678, 32'd0, 32'h1ffc);
        mem_row("sw", sw_i, 32'h3000, CACHE_RSP_DONE, JUNK, 32'd0, 32'h3008);
        mem_row("lw_misal", lw_i, 32'h2000, CACHE_RSP_MISALIGNED, JUNK, 32'd4, 32'h2010);
        mem_row("lw_access", lw_i, 32'h2000, CACHE_RSP_ACCESS_FAULT, JUNK, 32'd5, 32'h2010);
        mem_row("lw_page", lw_i, 32'h2000, CACHE_RSP_PAGE_FAULT, JUNK, 32'd13, 32'h2010);
        mem_row("sw_misal", sw_i, 32'h3000, CACHE_RSP_MISALIGNED, JUNK, 32'd6, 32'h3008);
        mem_row("sw_access", sw_i, 32'h3000, CACHE_RSP_ACCESS_FAULT, JUNK, 32'd7, 32'h3008);
        mem_row("sw_page", sw_i, 32'h3000, CACHE_RSP_PAGE_FAULT, JUNK, 32'd15, 32'h3008);

        illegal_row("bad_opcode", 32'h0000_007f);
        illegal_row("system", 32'h0000_0073);
        illegal_row("fence", 32'h0000_000f);
        illegal_row("jalr_f3", i_type(12'h000, 3'd1, OPC_JALR));
        illegal_row("bad_funct7", r_type(7'h01, 3'd0, 5'd3));
        illegal_row("branch_f3", b_type(13'h0010, 3'd2));
        illegal_row("store_f3", s_type(12'h000, 3'd4));
    endtask

    task automatic compare_word(input string test, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s: expected %08h actual %08h", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_bit(input string test, input string what,
                               input logic exp, input logic act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s: expected %0b actual %0b", test, what, exp, act);
            errors++;
        end
    endtask

    // Present one row and play the cache side until it retires
    task automatic apply_row(input int idx);
        test_row_t r;
        string     name;
        int        waited;
        bit        retired;
        int        errs_before;
        r           = rows[idx];
        name        = names[idx];
        errs_before = errors;
        waited      = 0;
        retired     = 1'b0;

        @(posedge clk);
        #1;
        f2e.instr           = r.instr;
        f2e.pc              = r.pc;
        regs[1]             = r.rs1_val;
        regs[2]             = r.rs2_val;
        cache_rsp.response  = CACHE_RSP_NONE;
        cache_rsp.load_data = '0;

        while (!retired) begin
            @(negedge clk);
            if (e2f.ready) begin
                retired = 1'b1;
            end else begin
                assert (r.mem) else begin
                    $display("%s: ready low on an instruction that should retire at once",
                             name);
                    errors++;
                end
                compare_word(name, "cmd", 32'(r.exp_cmd), 32'(cache_req.cmd));
                compare_word(name, "address", r.exp_addr, cache_req.address);
                if (r.exp_cmd == CACHE_CMD_STORE) begin
                    compare_word(name, "store_data", r.rs2_val, cache_req.store_data);
                    compare_word(name, "store_type", 32'(r.exp_size[1:0]),
                                 32'(cache_req.store_type));
                end else begin
                    compare_word(name, "load_type", 32'(r.exp_size),
                                 32'(cache_req.load_type));
                end
                compare_bit(name, "rd write while waiting", 1'b0, rd.write);
                compare_bit(name, "exc_start while waiting", 1'b0, e2f.exc_start);
                waited++;
                @(posedge clk);
                #1;
                if (waited == delays[idx]) begin
                    cache_rsp.response  = r.rsp;
                    cache_rsp.load_data = r.load_data;
                end
            end
        end

        compare_bit(name, "rd write", r.exp_wr, rd.write);
        if (r.exp_wr) begin
            compare_word(name, "rd value", r.exp_wdata, rd.wdata);
            compare_word(name, "rd addr", 32'(DEST_REG), 32'(rd.addr));
        end
        compare_bit(name, "branch_taken", r.exp_taken, e2f.branch_taken);
        if (r.exp_taken) begin
            compare_word(name, "branch_target", r.exp_target, e2f.branch_target);
        end
        compare_bit(name, "exc_start", r.exp_exc, e2f.exc_start);
        if (r.exp_exc) begin
            compare_word(name, "exc_cause", r.exp_cause, exc_cause);
            compare_word(name, "exc_epc", r.pc, e2f.exc_epc);
        end
        compare_word(name, "cmd at retire", 32'(CACHE_CMD_NONE), 32'(cache_req.cmd));
        if (r.mem) begin
            compare_word(name, "wait cycles", delays[idx], waited);
        end

        if (errors == errs_before) begin
            pass_cnt++;
            $display("ok    %s", name);
        end else begin
            fail_cnt++;
            $display("fail  %s", name);
        end
    endtask

    initial begin
        seed                = 32'h1e7e1461;
        rst_n               = 1'b0;
        f2e.instr           = 32'h0000_0013;
        f2e.pc              = '0;
        cache_rsp.response  = CACHE_RSP_NONE;
        cache_rsp.load_data = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end

        fill_table();
        limit = rows.size() * (MAX_DELAY + 4) + RST_CYCLES;

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (rows[i]) begin
            apply_row(i);
        end

        $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* rv_execute.f */
+incdir+.
rv_isa_pkg.sv
exec_bus_pkg.sv
rv_decode.sv
rv_alu.sv
rv_branch_cond.sv
lsu_sequencer.sv
rv_execute.sv
tb_rv_execute.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rv_execute -f rv_execute.f -o vsim &&
    ./obj_dir/vsim | tee sim.log &&
    grep -qF '*** TEST PASSED ***' sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed, see sim.log"; exit 1; }
